//--- hdl/stride_settings.svh
`ifndef STRIDE_SETTINGS_SVH
`define STRIDE_SETTINGS_SVH

// Width of one stream beat in bits
`define STR_DATA_BITS 64

// Element count carried by one command
`define STR_CNT_BITS 16

// Element width code, log2 of the byte count
`define STR_DW_BITS 2

`endif

//--- hdl/stride_pkg.sv
package stride_pkg;

    typedef enum logic [0:0] {
        pk_idle,
        pk_read
    } packer_state_e;

    // Four-phase command sequencing
    typedef enum logic [1:0] {
        cmd_idle,
        cmd_issue,
        cmd_release
    } cmd_state_e;

    typedef enum logic [1:0] {
        mg_idle,
        mg_lock0,
        mg_lock1
    } merge_state_e;

    typedef enum logic [0:0] {
        chan0,
        chan1
    } chan_e;

endpackage

//--- hdl/stride_intf.sv
`timescale 1ns/1ps
`include "stride_settings.svh"

// Valid/ready stream, one beat per handshake
interface stride_axis_if;
    logic                          tvalid;
    logic                          tready;
    logic [`STR_DATA_BITS-1:0]     tdata;
    logic [`STR_DATA_BITS/8-1:0]   tkeep;
    logic                          tlast;

    modport src (
        output tvalid, tdata, tkeep, tlast,
        input  tready
    );

    modport sink (
        input  tvalid, tdata, tkeep, tlast,
        output tready
    );
endinterface

// Per-channel command parameters
interface stride_params_if;
    logic                          valid;
    logic                          ready;
    logic [`STR_CNT_BITS-1:0]      count;
    logic [`STR_DW_BITS-1:0]       dwidth;

    modport m (
        output valid, count, dwidth,
        input  ready
    );

    modport s (
        input  valid, count, dwidth,
        output ready
    );
endinterface

//--- hdl/stride_cmd_ctrl.sv
`timescale 1ns/1ps
`include "stride_settings.svh"

module stride_cmd_ctrl (
    input  logic                        aclk,
    input  logic                        aresetn,
    input  logic                        cmd_req,
    input  stride_pkg::chan_e           cmd_chan,
    input  logic [`STR_CNT_BITS-1:0]    cmd_count,
    input  logic [`STR_DW_BITS-1:0]     cmd_dwidth,
    output logic                        cmd_ack,
    stride_params_if.m                  params0,
    stride_params_if.m                  params1
);
    import stride_pkg::*;

    cmd_state_e                 state_q;
    chan_e                      chan_q;
    logic [`STR_CNT_BITS-1:0]   count_q;
    logic [`STR_DW_BITS-1:0]    dwidth_q;
    logic                       sel_ready;

    assign sel_ready = (chan_q == chan1) ? params1.ready : params0.ready;

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            state_q <= cmd_idle;
            chan_q  <= chan0;
        end else begin
            case (state_q)
                cmd_idle: begin
                    if (cmd_req) begin
                        state_q <= cmd_issue;
                        chan_q  <= cmd_chan;
                    end
                end
                // Wait here until the packer is idle
                cmd_issue: begin
                    if (sel_ready) begin
                        state_q <= cmd_release;
                    end
                end
                cmd_release: begin
                    if (!cmd_req) begin
                        state_q <= cmd_idle;
                    end
                end
                default: state_q <= cmd_idle;
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (state_q == cmd_idle && cmd_req) begin
            count_q  <= cmd_count;
            dwidth_q <= cmd_dwidth;
        end
    end

    assign params0.valid  = (state_q == cmd_issue) && (chan_q == chan0);
    assign params1.valid  = (state_q == cmd_issue) && (chan_q == chan1);
    assign params0.count  = count_q;
    assign params1.count  = count_q;
    assign params0.dwidth = dwidth_q;
    assign params1.dwidth = dwidth_q;

    assign cmd_ack = (state_q == cmd_release);

endmodule

//--- hdl/stride_packer.sv
`timescale 1ns/1ps
`include "stride_settings.svh"

module stride_packer #(
    parameter int DATA_BITS = `STR_DATA_BITS
) (
    input  logic            aclk,
    input  logic            aresetn,
    stride_params_if.s      params,
    stride_axis_if.sink     axis_sink,
    stride_axis_if.src      axis_src
);
    import stride_pkg::*;

    localparam int BYTES    = DATA_BITS / 8;
    localparam int OFS_BITS = $clog2(BYTES);
    localparam int PTR_BITS = OFS_BITS + 1;

    packer_state_e              state_q, state_d;
    logic [`STR_CNT_BITS-1:0]   cnt_q, cnt_d;
    logic [`STR_DW_BITS-1:0]    dw_q, dw_d;
    logic [PTR_BITS-1:0]        ptr_in_q, ptr_in_d;
    logic                       ptr_out_q, ptr_out_d;
    logic                       val_q, val_d;
    logic                       last_q, last_d;
    logic [2*DATA_BITS-1:0]     data_q, data_d;
    logic [2*BYTES-1:0]         keep_q, keep_d;
    logic [PTR_BITS-1:0]        elem_bytes;
    logic [PTR_BITS-1:0]        ptr_next;
    logic                       take;

    // Byte pointer runs over both halves of the staging register
    assign elem_bytes = PTR_BITS'(1) << dw_q;
    assign ptr_next   = ptr_in_q + elem_bytes;
    assign take       = axis_sink.tvalid && axis_sink.tready;

    assign params.ready     = (state_q == pk_idle);
    assign axis_sink.tready = (state_q == pk_read) && (!val_q || axis_src.tready);

    assign axis_src.tvalid = val_q;
    assign axis_src.tdata  = data_q[ptr_out_q*DATA_BITS +: DATA_BITS];
    assign axis_src.tkeep  = keep_q[ptr_out_q*BYTES +: BYTES];
    assign axis_src.tlast  = last_q;

    always_comb begin
        state_d   = state_q;
        cnt_d     = cnt_q;
        dw_d      = dw_q;
        ptr_in_d  = ptr_in_q;
        ptr_out_d = ptr_out_q;
        val_d     = val_q && !axis_src.tready;
        last_d    = last_q;
        data_d    = data_q;
        keep_d    = keep_q;

        case (state_q)
            pk_idle: begin
                if (params.valid) begin
                    state_d = pk_read;
                    cnt_d   = params.count - 1'b1;
                    dw_d    = params.dwidth;
                end
            end
            pk_read: begin
                if (take) begin
                    // First element of a half starts from a clean beat
                    if (ptr_in_q[OFS_BITS-1:0] == '0) begin
                        data_d[ptr_in_q[PTR_BITS-1]*DATA_BITS +: DATA_BITS] = '0;
                        keep_d[ptr_in_q[PTR_BITS-1]*BYTES +: BYTES] = '0;
                    end
                    for (int i = 0; i < BYTES; i++) begin
                        if (i < elem_bytes) begin
                            data_d[(ptr_in_q + i)*8 +: 8] = axis_sink.tdata[i*8 +: 8];
                            keep_d[ptr_in_q + i] = axis_sink.tkeep[i];
                        end
                    end
                    // Half full or command done
                    if (cnt_q == '0 || ptr_next[OFS_BITS-1:0] == '0) begin
                        val_d     = 1'b1;
                        last_d    = (cnt_q == '0);
                        ptr_out_d = ptr_in_q[PTR_BITS-1];
                    end
                    if (cnt_q == '0) begin
                        state_d  = pk_idle;
                        ptr_in_d = '0;
                    end else begin
                        cnt_d    = cnt_q - 1'b1;
                        ptr_in_d = ptr_next;
                    end
                end
            end
            default: state_d = pk_idle;
        endcase
    end

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            state_q   <= pk_idle;
            cnt_q     <= '0;
            dw_q      <= '0;
            ptr_in_q  <= '0;
            ptr_out_q <= 1'b0;
            val_q     <= 1'b0;
            last_q    <= 1'b0;
        end else begin
            state_q   <= state_d;
            cnt_q     <= cnt_d;
            dw_q      <= dw_d;
            ptr_in_q  <= ptr_in_d;
            ptr_out_q <= ptr_out_d;
            val_q     <= val_d;
            last_q    <= last_d;
        end
    end

    always_ff @(posedge aclk) begin
        data_q <= data_d;
        keep_q <= keep_d;
    end

endmodule

//--- hdl/stream_merge.sv
`timescale 1ns/1ps
`include "stride_settings.svh"

module stream_merge (
    input  logic                            aclk,
    input  logic                            aresetn,
    stride_axis_if.sink                     in0,
    stride_axis_if.sink                     in1,
    output logic                            m_tvalid,
    input  logic                            m_tready,
    output logic [`STR_DATA_BITS-1:0]       m_tdata,
    output logic [`STR_DATA_BITS/8-1:0]     m_tkeep,
    output logic                            m_tlast,
    output stride_pkg::chan_e               m_tdest
);
    import stride_pkg::*;

    merge_state_e   state_q;
    chan_e          last_grant_q;
    chan_e          sel;
    logic           accept;

    always_comb begin
        case (state_q)
            mg_lock0: sel = chan0;
            mg_lock1: sel = chan1;
            default: begin
                // Round robin only matters when both are waiting
                if (in0.tvalid && in1.tvalid) begin
                    if (last_grant_q == chan0) begin
                        sel = chan1;
                    end else begin
                        sel = chan0;
                    end
                end else if (in1.tvalid) begin
                    sel = chan1;
                end else begin
                    sel = chan0;
                end
            end
        endcase
    end

    assign m_tvalid = (sel == chan1) ? in1.tvalid : in0.tvalid;
    assign m_tdata  = (sel == chan1) ? in1.tdata  : in0.tdata;
    assign m_tkeep  = (sel == chan1) ? in1.tkeep  : in0.tkeep;
    assign m_tlast  = (sel == chan1) ? in1.tlast  : in0.tlast;
    assign m_tdest  = sel;

    assign in0.tready = (sel == chan0) && m_tready;
    assign in1.tready = (sel == chan1) && m_tready;

    assign accept = m_tvalid && m_tready;

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            state_q      <= mg_idle;
            last_grant_q <= chan1;
        end else if (accept) begin
            last_grant_q <= sel;
            if (m_tlast) begin
                state_q <= mg_idle;
            end else if (sel == chan1) begin
                state_q <= mg_lock1;
            end else begin
                state_q <= mg_lock0;
            end
        end
    end

endmodule

//--- hdl/stride_top.sv
`timescale 1ns/1ps
`include "stride_settings.svh"

module stride_top (
    input  logic                            aclk,
    input  logic                            aresetn,
    input  logic                            cmd_req,
    input  stride_pkg::chan_e               cmd_chan,
    input  logic [`STR_CNT_BITS-1:0]        cmd_count,
    input  logic [`STR_DW_BITS-1:0]         cmd_dwidth,
    output logic                            cmd_ack,
    input  logic                            s0_tvalid,
    output logic                            s0_tready,
    input  logic [`STR_DATA_BITS-1:0]       s0_tdata,
    input  logic                            s1_tvalid,
    output logic                            s1_tready,
    input  logic [`STR_DATA_BITS-1:0]       s1_tdata,
    output logic                            m_tvalid,
    input  logic                            m_tready,
    output logic [`STR_DATA_BITS-1:0]       m_tdata,
    output logic [`STR_DATA_BITS/8-1:0]     m_tkeep,
    output logic                            m_tlast,
    output stride_pkg::chan_e               m_tdest
);

    stride_params_if params0 ();
    stride_params_if params1 ();
    stride_axis_if   s0_axis ();
    stride_axis_if   s1_axis ();
    stride_axis_if   p0_axis ();
    stride_axis_if   p1_axis ();

    // Raw inputs have every byte valid and no packet end
    assign s0_axis.tvalid = s0_tvalid;
    assign s0_axis.tdata  = s0_tdata;
    assign s0_axis.tkeep  = '1;
    assign s0_axis.tlast  = 1'b0;
    assign s0_tready      = s0_axis.tready;

    assign s1_axis.tvalid = s1_tvalid;
    assign s1_axis.tdata  = s1_tdata;
    assign s1_axis.tkeep  = '1;
    assign s1_axis.tlast  = 1'b0;
    assign s1_tready      = s1_axis.tready;

    stride_cmd_ctrl i_cmd_ctrl (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .cmd_req    (cmd_req),
        .cmd_chan   (cmd_chan),
        .cmd_count  (cmd_count),
        .cmd_dwidth (cmd_dwidth),
        .cmd_ack    (cmd_ack),
        .params0    (params0.m),
        .params1    (params1.m)
    );

    stride_packer #(.DATA_BITS(`STR_DATA_BITS)) i_packer0 (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .params     (params0.s),
        .axis_sink  (s0_axis.sink),
        .axis_src   (p0_axis.src)
    );

    stride_packer #(.DATA_BITS(`STR_DATA_BITS)) i_packer1 (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .params     (params1.s),
        .axis_sink  (s1_axis.sink),
        .axis_src   (p1_axis.src)
    );

    stream_merge i_merge (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .in0        (p0_axis.sink),
        .in1        (p1_axis.sink),
        .m_tvalid   (m_tvalid),
        .m_tready   (m_tready),
        .m_tdata    (m_tdata),
        .m_tkeep    (m_tkeep),
        .m_tlast    (m_tlast),
        .m_tdest    (m_tdest)
    );

endmodule

//--- bench/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 8
) (
    output logic aclk,
    output logic aresetn
);

    initial aclk = 1'b0;

    always #(PERIOD_NS / 2) aclk = ~aclk;

    // Release on a rising edge
    initial begin
        aresetn = 1'b0;
        repeat (RESET_CYCLES) @(posedge aclk);
        aresetn <= 1'b1;
    end

endmodule

//--- bench/tb_stride_top.sv
`timescale 1ns/1ps
`include "stride_settings.svh"

module tb_stride_top;
    import stride_pkg::*;

    localparam int N_ENTRIES    = 9;
    localparam int RESET_CYCLES = 8;

    typedef struct packed {
        chan_e                      chan;
        logic [`STR_CNT_BITS-1:0]   count;
        logic [`STR_DW_BITS-1:0]    dwidth;
        logic [7:0]                 stall;
        logic                       sync;
    } cmd_entry_t;

    typedef struct packed {
        logic [`STR_DATA_BITS-1:0]  data;
        logic [7:0]                 keep;
        logic                       last;
        logic [7:0]                 entry;
    } beat_t;

    // Stall 8'h00 selects random m_tready
    cmd_entry_t tbl [N_ENTRIES] = '{
        '{chan0, 16'd8,  2'd0, 8'hFF, 1'b1},
        '{chan1, 16'd5,  2'd1, 8'hFF, 1'b1},
        '{chan0, 16'd6,  2'd3, 8'hFF, 1'b1},
        '{chan0, 16'd20, 2'd1, 8'hFF, 1'b0},
        '{chan1, 16'd12, 2'd2, 8'hFF, 1'b1},
        '{chan1, 16'd9,  2'd3, 8'h00, 1'b0},
        '{chan0, 16'd33, 2'd0, 8'h00, 1'b0},
        '{chan0, 16'd7,  2'd2, 8'hAA, 1'b1},
        '{chan1, 16'd4,  2'd3, 8'h5B, 1'b1}
    };

    logic                           aclk;
    logic                           aresetn;
    logic                           cmd_req;
    chan_e                          cmd_chan;
    logic [`STR_CNT_BITS-1:0]       cmd_count;
    logic [`STR_DW_BITS-1:0]        cmd_dwidth;
    logic                           cmd_ack;
    logic                           s0_tvalid = 1'b0;
    logic                           s0_tready;
    logic [`STR_DATA_BITS-1:0]      s0_tdata = '0;
    logic                           s1_tvalid = 1'b0;
    logic                           s1_tready;
    logic [`STR_DATA_BITS-1:0]      s1_tdata = '0;
    logic                           m_tvalid;
    logic                           m_tready = 1'b0;
    logic [`STR_DATA_BITS-1:0]      m_tdata;
    logic [`STR_DATA_BITS/8-1:0]    m_tkeep;
    logic                           m_tlast;
    chan_e                          m_tdest;

    logic [`STR_DATA_BITS-1:0]      in0_q [$];
    logic [`STR_DATA_BITS-1:0]      in1_q [$];
    beat_t                          exp0_q [$];
    beat_t                          exp1_q [$];
    int                             entry_err [N_ENTRIES] = '{default: 0};
    int                             entry_beats [N_ENTRIES] = '{default: 0};
    int                             errors = 0;
    int                             beats_checked = 0;
    int                             done_cnt = 0;
    int                             limit_cycles;
    logic [15:0]                    data_lfsr = 16'd88;
    logic [15:0]                    rdy_lfsr = 16'd88;
    logic [7:0]                     stall_cur = 8'hFF;
    logic [2:0]                     stall_phase = '0;
    logic                           req_prev = 1'b0;
    logic                           in_pkt = 1'b0;
    chan_e                          pkt_chan = chan0;
    beat_t                          exp_beat;
    logic                           have_exp;
    logic [`STR_DATA_BITS-1:0]      mask;

    tb_clk_gen #(.PERIOD_NS(40), .RESET_CYCLES(RESET_CYCLES)) i_clk_gen (
        .aclk    (aclk),
        .aresetn (aresetn)
    );

    stride_top i_dut (.*);

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function int total_elements();
        int sum;
        sum = 0;
        for (int i = 0; i < N_ENTRIES; i++) begin
            sum += int'(tbl[i].count);
        end
        return sum;
    endfunction

    // Input words and the beats the packing rule predicts for them
    task automatic load_entry(input int e);
        logic [`STR_DATA_BITS-1:0] word;
        beat_t                     beat;
        int                        filled;
        int                        wbytes;
        filled = 0;
        wbytes = 1 << tbl[e].dwidth;
        beat   = '0;
        for (int k = 0; k < int'(tbl[e].count); k++) begin
            for (int i = 0; i < `STR_DATA_BITS; i++) begin
                word[i]   = data_lfsr[0];
                data_lfsr = lfsr_step(data_lfsr);
            end
            if (tbl[e].chan == chan1) in1_q.push_back(word);
            else in0_q.push_back(word);
            for (int b = 0; b < wbytes; b++) begin
                beat.data[filled*8 +: 8] = word[b*8 +: 8];
                filled++;
            end
            if (filled == 8 || k == int'(tbl[e].count) - 1) begin
                beat.keep  = (filled == 8) ? 8'hFF : 8'((1 << filled) - 1);
                beat.last  = (k == int'(tbl[e].count) - 1);
                beat.entry = 8'(e);
                if (tbl[e].chan == chan1) exp1_q.push_back(beat);
                else exp0_q.push_back(beat);
                beat   = '0;
                filled = 0;
            end
        end
        stall_cur = tbl[e].stall;
    endtask

    task automatic issue_command(input cmd_entry_t row);
        @(posedge aclk);
        cmd_req    <= 1'b1;
        cmd_chan   <= row.chan;
        cmd_count  <= row.count;
        cmd_dwidth <= row.dwidth;
        @(posedge aclk);
        while (!cmd_ack) @(posedge aclk);
        cmd_req <= 1'b0;
        @(posedge aclk);
        @(posedge aclk);
        assert (!cmd_ack) else begin
            errors++;
            $display("Error at %0t ns: cmd_ack still high one cycle after req was dropped",
                     $time);
        end
    endtask

    // Input drivers, one per channel
    always @(posedge aclk) begin
        if (s0_tvalid && s0_tready) void'(in0_q.pop_front());
        if (in0_q.size() != 0) begin
            s0_tvalid <= 1'b1;
            s0_tdata  <= in0_q[0];
        end else begin
            s0_tvalid <= 1'b0;
        end
    end

    always @(posedge aclk) begin
        if (s1_tvalid && s1_tready) void'(in1_q.pop_front());
        if (in1_q.size() != 0) begin
            s1_tvalid <= 1'b1;
            s1_tdata  <= in1_q[0];
        end else begin
            s1_tvalid <= 1'b0;
        end
    end

    always @(posedge aclk) begin
        if (stall_cur == 8'h00) begin
            m_tready <= rdy_lfsr[0];
            rdy_lfsr = lfsr_step(rdy_lfsr);
        end else begin
            m_tready <= stall_cur[stall_phase];
            stall_phase = stall_phase + 1'b1;
        end
    end

    // Ack may only follow a req seen on the previous edge
    always @(posedge aclk) begin
        if (aresetn) begin
            assert (!cmd_ack || req_prev) else begin
                errors++;
                $display("Error at %0t ns: cmd_ack went high without a pending req", $time);
            end
        end
        req_prev = cmd_req;
    end

    always @(posedge aclk) begin
        if (aresetn && m_tvalid && m_tready) begin
            have_exp = (m_tdest == chan1) ? (exp1_q.size() != 0) : (exp0_q.size() != 0);
            assert (have_exp) else begin
                errors++;
                $display("Output beat on channel %0d arrived with no packet expected", m_tdest);
            end
            if (have_exp) begin
                if (m_tdest == chan1) exp_beat = exp1_q.pop_front();
                else exp_beat = exp0_q.pop_front();
                assert (!in_pkt || m_tdest == pkt_chan) else begin
                    errors++;
                    $display("Channel %0d beat was interleaved into a channel %0d packet",
                             m_tdest, pkt_chan);
                end
                for (int b = 0; b < 8; b++) begin
                    mask[b*8 +: 8] = {8{exp_beat.keep[b]}};
                end
                assert (m_tkeep == exp_beat.keep && m_tlast == exp_beat.last &&
                        (m_tdata & mask) == (exp_beat.data & mask)) else begin
                    errors++;
                    entry_err[exp_beat.entry]++;
                    $display("Error at %0t ns: chan %0d got %h/%h/%b, expected %h/%h/%b",
                             $time, m_tdest, m_tdata, m_tkeep, m_tlast,
                             exp_beat.data, exp_beat.keep, exp_beat.last);
                end
                beats_checked++;
                entry_beats[exp_beat.entry]++;
                in_pkt   = !m_tlast;
                pkt_chan = m_tdest;
                if (exp_beat.last) begin
                    $display("Entry %0d: channel %0d, %0d elements of %0d bytes, %0d beats, %s",
                             exp_beat.entry, m_tdest, tbl[exp_beat.entry].count,
                             1 << tbl[exp_beat.entry].dwidth, entry_beats[exp_beat.entry],
                             (entry_err[exp_beat.entry] == 0) ? "ok" : "mismatch");
                    done_cnt++;
                end
            end
        end
    end

    initial begin
        limit_cycles = total_elements() * 4 + 200;
        repeat (limit_cycles + RESET_CYCLES) @(posedge aclk);
        $display("Timeout after %0d cycles: not every expected packet came out, the DUT hangs",
                 limit_cycles);
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        cmd_req    = 1'b0;
        cmd_chan   = chan0;
        cmd_count  = '0;
        cmd_dwidth = '0;
        wait (aresetn === 1'b1);
        @(posedge aclk);
        assert (!cmd_ack && !m_tvalid && !s0_tready && !s1_tready) else begin
            errors++;
            $display("Error at %0t ns: after reset cmd_ack=%b m_tvalid=%b s0_tready=%b s1_tready=%b",
                     $time, cmd_ack, m_tvalid, s0_tready, s1_tready);
        end
        for (int e = 0; e < N_ENTRIES; e++) begin
            issue_command(tbl[e]);
            @(negedge aclk);
            load_entry(e);
            if (tbl[e].sync) begin
                while (done_cnt != e + 1) @(posedge aclk);
            end
        end
        while (done_cnt != N_ENTRIES) @(posedge aclk);
        repeat (4) @(posedge aclk);
        $display("Summary: %0d entries, %0d beats checked, %0d errors",
                 done_cnt, beats_checked, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- tb.f
+incdir+hdl
hdl/stride_pkg.sv
hdl/stride_intf.sv
hdl/stride_cmd_ctrl.sv
hdl/stride_packer.sv
hdl/stream_merge.sv
hdl/stride_top.sv
bench/tb_clk_gen.sv
bench/tb_stride_top.sv

//--- Makefile
SIM       ?= verilator
TOP       ?= tb_stride_top
FILELIST  ?= tb.f
FLAGS     ?= --binary --timing --assert -Wno-fatal
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with $(SIM), run $(TOP), search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^STATUS: PASS$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
